//--- hw/mmio_defines.svh
`ifndef MMIO_DEFINES_SVH
`define MMIO_DEFINES_SVH

// Single-word register addresses
`define MMIO_ADDR_SEVEN_SEG 32'd255
`define MMIO_ADDR_RESET_PC 32'd259
`define MMIO_ADDR_MS 32'd267
`define MMIO_ADDR_US 32'd271
`define MMIO_ADDR_MATRIX 32'd275
`define MMIO_ADDR_GPIO_MODES 32'd279
`define MMIO_ADDR_GPIO_OUT 32'd283
`define MMIO_ADDR_GPIO_IN 32'd287

// Data RAM window, byte addresses 1024 to 2047
`define MMIO_RAM_BASE 1024
`define MMIO_RAM_WORDS 256
`define MMIO_RAM_INDEX_BITS 8

// Prescaler periods in clock cycles
`define MMIO_US_DIVIDE 8
`define MMIO_MS_DIVIDE 8333

// Reset values
`define MMIO_RESET_PC_VALUE 32'h3FC
`define MMIO_GPIO_MODES_RESET 8'hFF

// Number of GPIO lines
`define MMIO_GPIO_WIDTH 8

`endif

//--- hw/MmioPkg.sv
`include "mmio_defines.svh"

package MmioPkg;

	// Bus word
	typedef logic [31:0] Word;

	// One bit per GPIO line
	typedef logic [`MMIO_GPIO_WIDTH-1:0] GpioBits;

	// Address map regions
	typedef enum logic [3:0] {
		regionNone = 4'd0,
		regionSevenSeg = 4'd1,
		regionResetPc = 4'd2,
		regionMs = 4'd3,
		regionUs = 4'd4,
		regionMatrix = 4'd5,
		regionGpioModes = 4'd6,
		regionGpioOut = 4'd7,
		// Read only, writes are dropped
		regionGpioIn = 4'd8,
		regionRam = 4'd9
	} Region;

endpackage

//--- hw/BusDecoder.sv
`include "mmio_defines.svh"

module BusDecoder (
	input logic clk,
	input logic rst,
	input MmioPkg::Word address,
	input logic rd,
	input logic wr,
	output MmioPkg::Region writeRegion,
	output logic ramWe,
	output logic [`MMIO_RAM_INDEX_BITS-1:0] ramIndex,
	output MmioPkg::Region readRegion
);

	import MmioPkg::*;

	localparam Word RamFirst = Word'(`MMIO_RAM_BASE);
	localparam Word RamLast = Word'(`MMIO_RAM_BASE + 4 * `MMIO_RAM_WORDS - 1);

	Region region;
	logic inRam;

	always_comb begin
		inRam = (address >= RamFirst) && (address <= RamLast);
		region = regionNone;
		case (address)
			`MMIO_ADDR_SEVEN_SEG: region = regionSevenSeg;
			`MMIO_ADDR_RESET_PC: region = regionResetPc;
			`MMIO_ADDR_MS: region = regionMs;
			`MMIO_ADDR_US: region = regionUs;
			`MMIO_ADDR_MATRIX: region = regionMatrix;
			`MMIO_ADDR_GPIO_MODES: region = regionGpioModes;
			`MMIO_ADDR_GPIO_OUT: region = regionGpioOut;
			`MMIO_ADDR_GPIO_IN: region = regionGpioIn;
			default: begin
				// Anything else outside the RAM window stays unmapped
				if (inRam) begin
					region = regionRam;
				end
			end
		endcase
	end

	// Write side acts on the current edge
	always_comb begin
		writeRegion = wr ? region : regionNone;
		ramWe = wr && (region == regionRam);
		// Word index, byte bits dropped
		ramIndex = address[`MMIO_RAM_INDEX_BITS+1:2];
	end

	// Read side selects the data one cycle later
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			readRegion <= regionNone;
		end
		else begin
			readRegion <= rd ? region : regionNone;
		end
	end

	// A request is either a read or a write
	rdWrExclusive: assert property (@(posedge clk) disable iff (rst == 1'b0) !(rd && wr))
		else $error("rd and wr strobed on the same edge");

endmodule

//--- hw/DataRam.sv
`include "mmio_defines.svh"

module DataRam (
	input logic clk,
	input logic ramWe,
	input logic [`MMIO_RAM_INDEX_BITS-1:0] ramIndex,
	input MmioPkg::Word wrData,
	output MmioPkg::Word ramData
);

	import MmioPkg::*;

	Word mem [`MMIO_RAM_WORDS];

	// Whole-word write
	always_ff @(posedge clk) begin
		if (ramWe) begin
			mem[ramIndex] <= wrData;
		end
	end

	// Registered read on every edge, the decoder decides whether it is used
	always_ff @(posedge clk) begin
		ramData <= mem[ramIndex];
	end

endmodule

//--- hw/IoRegisters.sv
`include "mmio_defines.svh"

module IoRegisters (
	input logic clk,
	input logic rst,
	input MmioPkg::Region writeRegion,
	input MmioPkg::Word wrData,
	input logic frameDone,
	input MmioPkg::GpioBits gpioIn,
	output MmioPkg::Word sevenSeg,
	output MmioPkg::Word resetAddress,
	output MmioPkg::GpioBits gpioOe,
	output MmioPkg::GpioBits gpioOut,
	output MmioPkg::GpioBits gpioSampled,
	output logic swapRequest,
	output logic useSecondary
);

	import MmioPkg::*;

	// Seven-segment display and PC reset address
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			sevenSeg <= '0;
			resetAddress <= `MMIO_RESET_PC_VALUE;
		end
		else begin
			if (writeRegion == regionSevenSeg) begin
				sevenSeg <= wrData;
			end
			if (writeRegion == regionResetPc) begin
				resetAddress <= wrData;
			end
		end
	end

	// GPIO lines start as outputs driving low
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			gpioOe <= `MMIO_GPIO_MODES_RESET;
			gpioOut <= '0;
			gpioSampled <= '0;
		end
		else begin
			if (writeRegion == regionGpioModes) begin
				gpioOe <= wrData[`MMIO_GPIO_WIDTH-1:0];
			end
			if (writeRegion == regionGpioOut) begin
				gpioOut <= wrData[`MMIO_GPIO_WIDTH-1:0];
			end
			// Input sampled once per edge
			gpioSampled <= gpioIn;
		end
	end

	// Matrix double buffer handshake
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			swapRequest <= 1'b0;
			useSecondary <= 1'b0;
		end
		else begin
			if (writeRegion == regionMatrix) begin
				swapRequest <= wrData[0];
			end
			// Only flip buffers once the display has finished its frame
			if (frameDone && swapRequest) begin
				swapRequest <= 1'b0;
				useSecondary <= !useSecondary;
			end
		end
	end

	// No buffer flip in the middle of a frame
	swapOnFrameDone: assert property (
		@(posedge clk) disable iff (rst == 1'b0)
		!frameDone |=> $stable(useSecondary)
	) else $error("useSecondary changed without frameDone");

endmodule

//--- hw/Timebase.sv
`include "mmio_defines.svh"

module Timebase (
	input logic clk,
	input logic rst,
	output MmioPkg::Word msCount,
	output MmioPkg::Word usCount
);

	import MmioPkg::*;

	localparam int UsPreBits = $clog2(`MMIO_US_DIVIDE);
	localparam int MsPreBits = $clog2(`MMIO_MS_DIVIDE);
	localparam logic [UsPreBits-1:0] UsPreLast = UsPreBits'(`MMIO_US_DIVIDE - 1);
	localparam logic [MsPreBits-1:0] MsPreLast = MsPreBits'(`MMIO_MS_DIVIDE - 1);

	logic [UsPreBits-1:0] usPre;
	logic [MsPreBits-1:0] msPre;

	// Microsecond tick
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			usPre <= '0;
			usCount <= '0;
		end
		else if (usPre == UsPreLast) begin
			usPre <= '0;
			usCount <= usCount + Word'(1);
		end
		else begin
			usPre <= usPre + 1'b1;
		end
	end

	// Millisecond tick
	always_ff @(posedge clk or negedge rst) begin
		if (rst == 1'b0) begin
			msPre <= '0;
			msCount <= '0;
		end
		else if (msPre == MsPreLast) begin
			msPre <= '0;
			msCount <= msCount + Word'(1);
		end
		else begin
			msPre <= msPre + 1'b1;
		end
	end

endmodule

//--- hw/ReadMux.sv
module ReadMux (
	input MmioPkg::Region readRegion,
	input MmioPkg::Word ramData,
	input MmioPkg::Word sevenSeg,
	input MmioPkg::Word resetAddress,
	input MmioPkg::Word msCount,
	input MmioPkg::Word usCount,
	input logic swapRequest,
	input MmioPkg::GpioBits gpioOe,
	input MmioPkg::GpioBits gpioOut,
	input MmioPkg::GpioBits gpioSampled,
	output MmioPkg::Word rdData
);

	import MmioPkg::*;

	// Second stage of the access, selected by the registered region
	always_comb begin
		unique case (readRegion)
			regionSevenSeg: rdData = sevenSeg;
			regionResetPc: rdData = resetAddress;
			regionMs: rdData = msCount;
			regionUs: rdData = usCount;
			// Narrow values are zero extended
			regionMatrix: rdData = Word'(swapRequest);
			regionGpioModes: rdData = Word'(gpioOe);
			regionGpioOut: rdData = Word'(gpioOut);
			regionGpioIn: rdData = Word'(gpioSampled);
			regionRam: rdData = ramData;
			default: rdData = '0;
		endcase
	end

endmodule

//--- hw/MmioSystem.sv
`include "mmio_defines.svh"

module MmioSystem (
	input logic clk,
	input logic rst,
	input MmioPkg::Word address,
	input MmioPkg::Word wrData,
	input logic rd,
	input logic wr,
	input logic frameDone,
	input MmioPkg::GpioBits gpioIn,
	output MmioPkg::Word rdData,
	output MmioPkg::Word sevenSeg,
	output MmioPkg::Word resetAddress,
	output MmioPkg::GpioBits gpioOe,
	output MmioPkg::GpioBits gpioOut,
	output logic useSecondary
);

	// Decoder outputs
	MmioPkg::Region writeRegion;
	MmioPkg::Region readRegion;
	logic ramWe;
	logic [`MMIO_RAM_INDEX_BITS-1:0] ramIndex;

	// Storage toward the read mux
	MmioPkg::Word ramData;
	MmioPkg::Word msCount;
	MmioPkg::Word usCount;
	MmioPkg::GpioBits gpioSampled;
	logic swapRequest;

	BusDecoder busDecoder (
		.clk(clk),
		.rst(rst),
		.address(address),
		.rd(rd),
		.wr(wr),
		.writeRegion(writeRegion),
		.ramWe(ramWe),
		.ramIndex(ramIndex),
		.readRegion(readRegion)
	);

	DataRam dataRam (
		.clk(clk),
		.ramWe(ramWe),
		.ramIndex(ramIndex),
		.wrData(wrData),
		.ramData(ramData)
	);

	IoRegisters ioRegisters (
		.clk(clk),
		.rst(rst),
		.writeRegion(writeRegion),
		.wrData(wrData),
		.frameDone(frameDone),
		.gpioIn(gpioIn),
		.sevenSeg(sevenSeg),
		.resetAddress(resetAddress),
		.gpioOe(gpioOe),
		.gpioOut(gpioOut),
		.gpioSampled(gpioSampled),
		.swapRequest(swapRequest),
		.useSecondary(useSecondary)
	);

	Timebase timebase (
		.clk(clk),
		.rst(rst),
		.msCount(msCount),
		.usCount(usCount)
	);

	ReadMux readMux (
		.readRegion(readRegion),
		.ramData(ramData),
		.sevenSeg(sevenSeg),
		.resetAddress(resetAddress),
		.msCount(msCount),
		.usCount(usCount),
		.swapRequest(swapRequest),
		.gpioOe(gpioOe),
		.gpioOut(gpioOut),
		.gpioSampled(gpioSampled),
		.rdData(rdData)
	);

endmodule

//--- dv/MmioSystemTb.sv
`include "mmio_defines.svh"

module MmioSystemTb;

	import MmioPkg::*;

	typedef enum logic [2:0] {
		opIdle,
		opRead,
		opWrite,
		opFrame,
		opGpio
	} Op;

	// One bus cycle and the state expected right after it
	typedef struct {
		Op op;
		Word address;
		Word data;
		Word expRead;
		Word expSevenSeg;
		Word expResetAddress;
		GpioBits expOe;
		GpioBits expOut;
		logic expSecondary;
	} Step;

	localparam int UsGap = 40;
	localparam int MsGap = 100;
	localparam int RamWrites = 8;

	logic clk;
	logic rst;
	Word address;
	Word wrData;
	logic rd;
	logic wr;
	logic frameDone;
	GpioBits gpioIn;
	Word rdData;
	Word sevenSeg;
	Word resetAddress;
	GpioBits gpioOe;
	GpioBits gpioOut;
	logic useSecondary;

	Step steps[$];
	int cycles = 0;
	int cycleLimit = 1000000;

	// Reference model state
	Word modelSevenSeg;
	Word modelResetPc;
	GpioBits modelOe;
	GpioBits modelOut;
	GpioBits modelGpioIn;
	logic modelRequest;
	logic modelSecondary;
	Word modelRam [`MMIO_RAM_WORDS];

	MmioSystem DUT (
		.clk(clk),
		.rst(rst),
		.address(address),
		.wrData(wrData),
		.rd(rd),
		.wr(wr),
		.frameDone(frameDone),
		.gpioIn(gpioIn),
		.rdData(rdData),
		.sevenSeg(sevenSeg),
		.resetAddress(resetAddress),
		.gpioOe(gpioOe),
		.gpioOut(gpioOut),
		.useSecondary(useSecondary)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	always @(posedge clk) begin
		cycles = cycles + 1;
		if (cycles > cycleLimit) begin
			$display("Timeout after %0d cycles, the test sequence never finished", cycles);
			$display("Some tests failed");
			$fatal(1, "Simulation stopped by the cycle limit");
		end
	end

	task automatic checkValue(input string name, input Word actual, input Word expected);
		if (actual !== expected) begin
			$display("** Error at time %0t: %s expected 0x%08h, got 0x%08h",
				$time, name, expected, actual);
			$display("Some tests failed");
			$fatal(1, "Stopping at the first mismatch");
		end
	endtask

	function automatic logic inRam(input Word addr);
		return (addr >= Word'(`MMIO_RAM_BASE)) &&
			(addr < Word'(`MMIO_RAM_BASE + 4 * `MMIO_RAM_WORDS));
	endfunction

	// Value a read returns in the cycle after its edge
	function automatic Word modelRead(input Word addr);
		Word value;
		value = '0;
		if (inRam(addr)) begin
			value = modelRam[(addr - Word'(`MMIO_RAM_BASE)) >> 2];
		end
		else begin
			case (addr)
				`MMIO_ADDR_SEVEN_SEG: value = modelSevenSeg;
				`MMIO_ADDR_RESET_PC: value = modelResetPc;
				`MMIO_ADDR_MATRIX: value = Word'(modelRequest);
				`MMIO_ADDR_GPIO_MODES: value = Word'(modelOe);
				`MMIO_ADDR_GPIO_OUT: value = Word'(modelOut);
				`MMIO_ADDR_GPIO_IN: value = Word'(modelGpioIn);
				default: value = '0;
			endcase
		end
		return value;
	endfunction

	task automatic modelWrite(input Word addr, input Word data);
		if (inRam(addr)) begin
			modelRam[(addr - Word'(`MMIO_RAM_BASE)) >> 2] = data;
		end
		else begin
			case (addr)
				`MMIO_ADDR_SEVEN_SEG: modelSevenSeg = data;
				`MMIO_ADDR_RESET_PC: modelResetPc = data;
				`MMIO_ADDR_MATRIX: modelRequest = data[0];
				`MMIO_ADDR_GPIO_MODES: modelOe = data[`MMIO_GPIO_WIDTH-1:0];
				`MMIO_ADDR_GPIO_OUT: modelOut = data[`MMIO_GPIO_WIDTH-1:0];
				default: begin
				end
			endcase
		end
	endtask

	task automatic addStep(input Op op, input Word addr, input Word data);
		Step s;
		s.op = op;
		s.address = addr;
		s.data = data;
		s.expRead = '0;
		case (op)
			opRead: s.expRead = modelRead(addr);
			opWrite: modelWrite(addr, data);
			opFrame: begin
				// Swap only when a request is pending
				if (modelRequest) begin
					modelRequest = 1'b0;
					modelSecondary = !modelSecondary;
				end
			end
			opGpio: modelGpioIn = data[`MMIO_GPIO_WIDTH-1:0];
			default: begin
			end
		endcase
		s.expSevenSeg = modelSevenSeg;
		s.expResetAddress = modelResetPc;
		s.expOe = modelOe;
		s.expOut = modelOut;
		s.expSecondary = modelSecondary;
		steps.push_back(s);
	endtask

	task automatic buildTable();
		Word ramAddr [RamWrites];
		modelSevenSeg = '0;
		modelResetPc = `MMIO_RESET_PC_VALUE;
		modelOe = `MMIO_GPIO_MODES_RESET;
		modelOut = '0;
		modelGpioIn = '0;
		modelRequest = 1'b0;
		modelSecondary = 1'b0;
		// Reset values read back
		addStep(opRead, `MMIO_ADDR_RESET_PC, '0);
		addStep(opRead, `MMIO_ADDR_GPIO_MODES, '0);
		addStep(opRead, `MMIO_ADDR_GPIO_OUT, '0);
		addStep(opRead, `MMIO_ADDR_MATRIX, '0);
		addStep(opIdle, '0, '0);
		// RAM, one back-to-back pair then a burst
		for (int i = 0; i < RamWrites; i++) begin
			ramAddr[i] = Word'(`MMIO_RAM_BASE) + Word'(4 * ($urandom % `MMIO_RAM_WORDS));
			addStep(opWrite, ramAddr[i], $urandom);
			if (i == 0) begin
				addStep(opRead, ramAddr[i], '0);
			end
		end
		for (int i = 0; i < RamWrites; i++) begin
			addStep(opRead, ramAddr[i], '0);
		end
		addStep(opWrite, `MMIO_ADDR_SEVEN_SEG, $urandom);
		addStep(opRead, `MMIO_ADDR_SEVEN_SEG, '0);
		addStep(opWrite, `MMIO_ADDR_RESET_PC, $urandom);
		addStep(opRead, `MMIO_ADDR_RESET_PC, '0);
		// Unmapped addresses around the map
		addStep(opWrite, 32'd300, $urandom);
		addStep(opRead, 32'd300, '0);
		addStep(opRead, 32'd0, '0);
		addStep(opRead, 32'd1023, '0);
		addStep(opRead, 32'd2048, '0);
		addStep(opIdle, '0, '0);
		// GPIO
		addStep(opWrite, `MMIO_ADDR_GPIO_MODES, $urandom);
		addStep(opWrite, `MMIO_ADDR_GPIO_OUT, $urandom);
		addStep(opRead, `MMIO_ADDR_GPIO_MODES, '0);
		addStep(opRead, `MMIO_ADDR_GPIO_OUT, '0);
		addStep(opGpio, '0, $urandom);
		addStep(opIdle, '0, '0);
		addStep(opRead, `MMIO_ADDR_GPIO_IN, '0);
		addStep(opGpio, '0, $urandom);
		addStep(opWrite, `MMIO_ADDR_GPIO_IN, $urandom);
		addStep(opRead, `MMIO_ADDR_GPIO_IN, '0);
		// Matrix swap handshake
		addStep(opFrame, '0, '0);
		addStep(opWrite, `MMIO_ADDR_MATRIX, 32'd1);
		addStep(opRead, `MMIO_ADDR_MATRIX, '0);
		addStep(opIdle, '0, '0);
		addStep(opIdle, '0, '0);
		addStep(opFrame, '0, '0);
		addStep(opRead, `MMIO_ADDR_MATRIX, '0);
		addStep(opFrame, '0, '0);
		addStep(opWrite, `MMIO_ADDR_MATRIX, 32'd1);
		addStep(opFrame, '0, '0);
		addStep(opRead, `MMIO_ADDR_MATRIX, '0);
	endtask

	task automatic driveStep(input Step s);
		address = s.address;
		wrData = s.data;
		rd = (s.op == opRead);
		wr = (s.op == opWrite);
		frameDone = (s.op == opFrame);
		// gpioIn holds its level until the next GPIO step
		if (s.op == opGpio) begin
			gpioIn = s.data[`MMIO_GPIO_WIDTH-1:0];
		end
	endtask

	task automatic checkStep(input Step s);
		checkValue("rdData", rdData, s.expRead);
		checkValue("sevenSeg", sevenSeg, s.expSevenSeg);
		checkValue("resetAddress", resetAddress, s.expResetAddress);
		checkValue("gpioOe", Word'(gpioOe), Word'(s.expOe));
		checkValue("gpioOut", Word'(gpioOut), Word'(s.expOut));
		checkValue("useSecondary", Word'(useSecondary), Word'(s.expSecondary));
	endtask

	// Called on a falling edge, returns on the next one
	task automatic readWord(input Word addr, output Word value);
		address = addr;
		rd = 1'b1;
		@(negedge clk);
		value = rdData;
		rd = 1'b0;
		address = '0;
	endtask

	initial begin
		Word usFirst;
		Word usSecond;
		Word usStep;
		Word msFirst;
		Word msSecond;
		Word msStep;
		void'($urandom(39));
		rst = 1'b0;
		address = '0;
		wrData = '0;
		rd = 1'b0;
		wr = 1'b0;
		frameDone = 1'b0;
		gpioIn = '0;
		buildTable();
		cycleLimit = 2 * steps.size() + UsGap + MsGap + 100;
		repeat (5) @(posedge clk);
		@(negedge clk);
		rst = 1'b1;
		checkValue("resetAddress", resetAddress, `MMIO_RESET_PC_VALUE);
		checkValue("gpioOe", Word'(gpioOe), Word'(`MMIO_GPIO_MODES_RESET));
		checkValue("gpioOut", Word'(gpioOut), '0);
		checkValue("useSecondary", Word'(useSecondary), '0);
		checkValue("rdData", rdData, '0);
		foreach (steps[i]) begin
			driveStep(steps[i]);
			@(negedge clk);
			checkStep(steps[i]);
		end
		wr = 1'b0;
		frameDone = 1'b0;
		// Timebase, read edges exactly UsGap and MsGap cycles apart
		readWord(`MMIO_ADDR_US, usFirst);
		repeat (UsGap - 1) @(negedge clk);
		readWord(`MMIO_ADDR_US, usSecond);
		usStep = usSecond - usFirst;
		if ((usStep + 1 < UsGap / `MMIO_US_DIVIDE) || (usStep > UsGap / `MMIO_US_DIVIDE + 1)) begin
			checkValue("usCount step", usStep, Word'(UsGap / `MMIO_US_DIVIDE));
		end
		readWord(`MMIO_ADDR_MS, msFirst);
		repeat (MsGap - 1) @(negedge clk);
		readWord(`MMIO_ADDR_MS, msSecond);
		msStep = msSecond - msFirst;
		if (msStep > 1) begin
			checkValue("msCount step", msStep, 32'd1);
		end
		@(negedge clk);
		checkValue("rdData", rdData, '0);
		$display("All tests passed");
		$finish;
	end

endmodule

//--- sources.f
+incdir+hw
hw/MmioPkg.sv
hw/BusDecoder.sv
hw/DataRam.sv
hw/IoRegisters.sv
hw/Timebase.sv
hw/ReadMux.sv
hw/MmioSystem.sv
dv/MmioSystemTb.sv

//--- Bender.yml
package:
  name: mmio_system

sources:
  - include_dirs:
      - hw
    files:
      - hw/MmioPkg.sv
      - hw/BusDecoder.sv
      - hw/DataRam.sv
      - hw/IoRegisters.sv
      - hw/Timebase.sv
      - hw/ReadMux.sv
      - hw/MmioSystem.sv
      - target: test
        files:
          - dv/MmioSystemTb.sv
